// ==== filelist.f ====
design/aluPkg.sv
design/cla4.sv
design/cla32.sv
design/alu.sv
design/aluApbRegs.sv
design/aluApbTop.sv
verif/clkGen.sv
verif/aluTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the APB ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module aluTb \
    -f filelist.f -o aluSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/aluSim > sim.log 2>&1
simStatus=$?
cat sim.log

if grep -q "=== FAIL ===" sim.log; then
    exit 1
fi
if [ $simStatus -ne 0 ]; then
    echo "Simulator exited with status $simStatus"
    exit 1
fi
exit 0

// ==== verif/aluTb.sv ====
/*
  Testbench for the APB ALU peripheral: APB tasks, LCG stimulus,
  reference model, comparing process and cycle timeout
*/
`timescale 1ns/10ps
`default_nettype none

module aluTb import aluPkg::*; ();

    typedef struct packed {
        regAddrT    addr;
        wordT       data;
        logic       checkData;
        logic       err;
        logic [3:0] waits;
    } xferT;

    localparam int numRandom     = 300;
    localparam int numDirected   = 48;
    // About 11 cycles per command plus half again as margin
    localparam int timeoutCycles = (numRandom + numDirected) * 11 * 3 / 2 + 200;

    logic    clk;
    logic    rstN;
    logic    pSel;
    logic    pEnable;
    logic    pWrite;
    regAddrT pAddr;
    wordT    pWData;
    wordT    pRData;
    logic    pReady;
    logic    pSlvErr;

    xferT    expQ[$];
    xferT    actQ[$];
    event    xferDone;
    int      nXfers = 0;
    int      nChecked = 0;
    int      cycleCount = 0;
    wordT    lcgState = 32'h99b7;

    // Register contents as software expects them
    wordT    modelOpA = '0;
    wordT    modelOpB = '0;
    opCodeT  modelOp = '0;
    aluRespT modelResp = '0;
    logic    modelValid = 1'b0;

    wordT    cornerA [6] = '{32'h0, 32'h80000000, 32'h7FFFFFFF,
                             32'hFFFFFFFF, 32'h80000000, 32'hFFFFFFFF};
    wordT    cornerB [6] = '{32'h0, 32'h7FFFFFFF, 32'h80000000,
                             32'h0, 32'h80000000, 32'hFFFFFFFF};
    opCodeT  cornerOps [8] = '{opSub, opBeqz, opBnez, opBltz,
                               opBgez, opEq, opLt, opLe};

    clkGen uClkGen (
        .clk  (clk),
        .rstN (rstN)
    );

    aluApbTop DUT (
        .clk     (clk),
        .rstN    (rstN),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWData  (pWData),
        .pRData  (pRData),
        .pReady  (pReady),
        .pSlvErr (pSlvErr)
    );

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    function automatic wordT lcgNext();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    // Operation rules of the ALU
    function automatic aluRespT refAlu(input wordT a, input wordT b, input opCodeT op);
        aluRespT r;
        r = '0;
        case (op)
            opAdd:   r.result = a + b;
            opSub:   r.result = b - a;
            opXor:   r.result = a ^ b;
            opAndn:  r.result = a & ~b;
            opBeqz:  r.isTaken = (a == 32'd0);
            opBnez:  r.isTaken = (a != 32'd0);
            opBltz:  r.isTaken = ($signed(a) < 0);
            opBgez:  r.isTaken = ($signed(a) >= 0);
            opEq:    r.result = (a == b) ? 32'd1 : 32'd0;
            opLt:    r.result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            opLe:    r.result = ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
            opPass:  r.result = b;
            opSlbi:  r.result = {a[15:0], b[15:0]};
            default: r = '0;
        endcase
        return r;
    endfunction

    // Register map error rules
    function automatic logic accessErr(input logic write, input regAddrT addr, input wordT data);
        case (addr)
            addrOpA, addrOpB:       return 1'b0;
            addrCmd:                return write && (data[3:0] > opSlbi);
            addrResult, addrStatus: return write;
            default:                return 1'b1;
        endcase
    endfunction

    // One APB transfer, entered 1 ns after a rising edge
    task automatic apbXfer(input logic write, input regAddrT addr, input wordT data);
        xferT act;
        int   waits;
        logic done;
        act   = '0;
        waits = 0;
        done  = 1'b0;
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = write;
        pAddr   = addr;
        pWData  = data;
        @(posedge clk);
        #1 pEnable = 1'b1;
        while (!done) begin
            // Mid-cycle sample of the access cycle
            @(negedge clk);
            if (pReady) begin
                done     = 1'b1;
                act.data = pRData;
                act.err  = pSlvErr;
            end else begin
                waits++;
                assert (waits < 8) else failRun("pReady stayed low for 8 access cycles");
            end
            @(posedge clk);
            #1;
        end
        pSel       = 1'b0;
        pEnable    = 1'b0;
        act.addr   = addr;
        act.waits  = 4'(waits);
        nXfers++;
        actQ.push_back(act);
        -> xferDone;
    endtask

    task automatic writeReg(input regAddrT addr, input wordT data);
        xferT exp;
        exp       = '0;
        exp.addr  = addr;
        exp.err   = accessErr(1'b1, addr, data);
        if (!exp.err) begin
            if (addr == addrOpA) begin
                modelOpA = data;
            end else if (addr == addrOpB) begin
                modelOpB = data;
            end else if (addr == addrCmd) begin
                modelOp    = data[3:0];
                modelResp  = refAlu(modelOpA, modelOpB, modelOp);
                modelValid = 1'b1;
                exp.waits  = 4'd1;
            end
        end
        expQ.push_back(exp);
        apbXfer(1'b1, addr, data);
    endtask

    task automatic readReg(input regAddrT addr);
        xferT exp;
        exp           = '0;
        exp.addr      = addr;
        exp.err       = accessErr(1'b0, addr, '0);
        exp.checkData = !exp.err;
        case (addr)
            addrOpA:    exp.data = modelOpA;
            addrOpB:    exp.data = modelOpB;
            addrCmd:    exp.data = {28'd0, modelOp};
            addrResult: exp.data = modelResp.result;
            addrStatus: exp.data = {30'd0, modelValid, modelResp.isTaken};
            default:    exp.data = '0;
        endcase
        expQ.push_back(exp);
        apbXfer(1'b0, addr, '0);
    endtask

    task automatic runCommand(input wordT a, input wordT b, input opCodeT op);
        writeReg(addrOpA, a);
        writeReg(addrOpB, b);
        writeReg(addrCmd, {28'd0, op});
        readReg(addrResult);
        readReg(addrStatus);
    endtask

    // Compares each completed transfer with the expected one
    initial begin : compareProc
        xferT exp;
        xferT act;
        forever begin
            @(xferDone);
            while (actQ.size() > 0) begin
                assert (expQ.size() > 0) else failRun("transfer completed with nothing expected");
                exp = expQ.pop_front();
                act = actQ.pop_front();
                nChecked++;
                assert (act.err == exp.err) else failRun($sformatf(
                    "error at %0t: pSlvErr at 0x%02h expected %0b got %0b",
                    $time, exp.addr, exp.err, act.err));
                assert (act.waits == exp.waits) else failRun($sformatf(
                    "error at %0t: pReady wait cycles at 0x%02h expected %0d got %0d",
                    $time, exp.addr, exp.waits, act.waits));
                assert (!exp.checkData || act.data == exp.data) else failRun($sformatf(
                    "error at %0t: pRData at 0x%02h expected 0x%08h got 0x%08h",
                    $time, exp.addr, exp.data, act.data));
            end
        end
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= timeoutCycles) begin
            $display("Timeout: the tests did not finish within %0d cycles", timeoutCycles);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    initial begin : stimulus
        wordT a;
        opCodeT op;
        pSel    = 1'b0;
        pEnable = 1'b0;
        pWrite  = 1'b0;
        pAddr   = '0;
        pWData  = '0;
        @(posedge rstN);
        @(posedge clk);
        #1;
        // Reset values
        readReg(addrOpA);
        readReg(addrOpB);
        readReg(addrResult);
        readReg(addrStatus);
        // Operand read-back
        for (int i = 0; i < 4; i++) begin
            a = lcgNext();
            writeReg(addrOpA, a);
            writeReg(addrOpB, ~a);
            readReg(addrOpA);
            readReg(addrOpB);
        end
        for (int i = 0; i < numRandom; i++) begin
            a  = lcgNext();
            op = opCodeT'((lcgNext() >> 8) % 13);
            runCommand(a, lcgNext(), op);
        end
        // Sign and zero corners
        for (int p = 0; p < 6; p++) begin
            for (int o = 0; o < 8; o++) begin
                runCommand(cornerA[p], cornerB[p], cornerOps[o]);
            end
        end
        // Error responses leave RESULT and STATUS alone
        for (int k = 13; k < 16; k++) begin
            writeReg(addrCmd, 32'(k));
        end
        readReg(addrCmd);
        writeReg(addrResult, 32'hDEADBEEF);
        writeReg(addrStatus, 32'h3);
        writeReg(5'h14, 32'h12345678);
        readReg(5'h1C);
        readReg(5'h02);
        readReg(addrResult);
        readReg(addrStatus);
        @(posedge clk);
        if (expQ.size() == 0 && nChecked == nXfers) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            $display("Checked %0d of %0d transfers", nChecked, nXfers);
            $display("=== FAIL ===");
            $fatal(1, "transfers left unchecked");
        end
    end

endmodule

`default_nettype wire

// ==== verif/clkGen.sv ====
/*
  Testbench clock and reset: 10 ns clock, reset low for 3 cycles
*/
`timescale 1ns/10ps
`default_nettype none

module clkGen (
    output logic clk,
    output logic rstN
);

    localparam int halfPeriod = 5;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    // Release 1 ns after the third rising edge
    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

// ==== design/aluApbTop.sv ====
/*
  APB ALU peripheral top: register block and ALU
*/
`timescale 1ns/10ps
`default_nettype none

module aluApbTop import aluPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    pSel,
    input  logic    pEnable,
    input  logic    pWrite,
    input  regAddrT pAddr,
    input  wordT    pWData,
    output wordT    pRData,
    output logic    pReady,
    output logic    pSlvErr
);

    aluReqT  aluReq;
    aluRespT aluResp;

    aluApbRegs uRegs (
        .clk     (clk),
        .rstN    (rstN),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWData  (pWData),
        .pRData  (pRData),
        .pReady  (pReady),
        .pSlvErr (pSlvErr),
        .aluReq  (aluReq),
        .aluResp (aluResp)
    );

    alu uAlu (
        .req  (aluReq),
        .resp (aluResp)
    );

endmodule

`default_nettype wire

// ==== design/aluApbRegs.sv ====
/*
  APB slave for the ALU: OPA, OPB, CMD, RESULT and STATUS registers,
  address decode, error response and the CMD wait-state FSM
*/
`timescale 1ns/10ps
`default_nettype none

module aluApbRegs import aluPkg::*; (
    input  logic    clk,
    input  logic    rstN,
    input  logic    pSel,
    input  logic    pEnable,
    input  logic    pWrite,
    input  regAddrT pAddr,
    input  wordT    pWData,
    output wordT    pRData,
    output logic    pReady,
    output logic    pSlvErr,
    output aluReqT  aluReq,
    input  aluRespT aluResp
);

    accessStateT state;
    accessStateT nextState;

    wordT    opA;
    wordT    opB;
    opCodeT  cmdOp;
    aluRespT respReg;
    logic    validReg;

    opCodeT  wrOp;
    logic    setup;
    logic    access;
    logic    isCmdWrite;
    logic    opValid;
    logic    isErr;
    logic    launch;
    logic    wrDone;

    assign setup      = pSel & ~pEnable;
    assign access     = pSel & pEnable;
    assign wrOp       = pWData[3:0];
    assign opValid    = (wrOp <= opSlbi);
    assign isCmdWrite = pWrite & (pAddr == addrCmd);

    // Decode errors: read-only writes, unmapped offsets, bad opcodes
    always_comb begin
        case (pAddr)
            addrOpA, addrOpB:         isErr = 1'b0;
            addrCmd:                  isErr = pWrite & ~opValid;
            addrResult, addrStatus:   isErr = pWrite;
            default:                  isErr = 1'b1;
        endcase
    end

    // First access cycle of a valid command
    assign launch  = access & isCmdWrite & opValid & (state == stIdle);
    assign pReady  = ~launch;
    assign pSlvErr = access & isErr;
    assign wrDone  = access & pWrite & pReady & ~isErr;

    always_comb begin
        pRData = '0;
        if (access && !pWrite) begin
            case (pAddr)
                addrOpA:    pRData = opA;
                addrOpB:    pRData = opB;
                addrCmd:    pRData = {28'b0, cmdOp};
                addrResult: pRData = respReg.result;
                addrStatus: pRData = {30'b0, validReg, respReg.isTaken};
                default:    pRData = '0;
            endcase
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            stIdle:  nextState = launch ? stExec : stIdle;
            stExec:  nextState = stIdle;
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= stIdle;
            opA      <= '0;
            opB      <= '0;
            cmdOp    <= opAdd;
            respReg  <= '0;
            validReg <= 1'b0;
        end else begin
            state <= nextState;
            if (wrDone && pAddr == addrOpA) begin
                opA <= pWData;
            end
            if (wrDone && pAddr == addrOpB) begin
                opB <= pWData;
            end
            // Write data is stable from setup, so the ALU sees the new
            // opcode during the first access cycle
            if (setup && isCmdWrite && opValid) begin
                cmdOp <= wrOp;
            end
            if (launch) begin
                respReg  <= aluResp;
                validReg <= 1'b1;
            end
        end
    end

    assign aluReq = '{a: opA, b: opB, op: cmdOp};

endmodule

`default_nettype wire

// ==== design/alu.sv ====
/*
  Combinational 32-bit ALU: opcode decode, adder operand steering,
  logic ops, branch conditions, signed compares, pass and shift-insert
*/
`timescale 1ns/10ps
`default_nettype none

module alu import aluPkg::*; (
    input  aluReqT  req,
    output aluRespT resp
);

    wordT aIn;
    wordT bIn;
    logic carryIn;
    wordT addSum;
    wordT result;
    logic taken;
    logic signsDiffer;
    logic diffZero;
    logic lessThan;
    logic lessEqual;

    cla32 uAdder (
        .a   (aIn),
        .b   (bIn),
        .cin (carryIn),
        .sum (addSum)
    );

    // Adder operand steering
    always_comb begin
        aIn     = req.a;
        bIn     = req.b;
        carryIn = 1'b0;
        case (req.op)
            // B - A as B + ~A + 1
            opSub: begin
                aIn     = req.b;
                bIn     = ~req.a;
                carryIn = 1'b1;
            end
            // Compares look at A - B
            opEq, opLt, opLe: begin
                aIn     = req.a;
                bIn     = ~req.b;
                carryIn = 1'b1;
            end
            default: begin
                aIn     = req.a;
                bIn     = req.b;
                carryIn = 1'b0;
            end
        endcase
    end

    // Sign-split compare
    // Differing signs decide directly; equal signs cannot overflow
    assign signsDiffer = req.a[31] ^ req.b[31];
    assign diffZero    = (addSum == '0);
    assign lessThan    = signsDiffer ? req.a[31] : addSum[31];
    assign lessEqual   = signsDiffer ? req.a[31] : (addSum[31] | diffZero);

    // Result select
    always_comb begin
        result = '0;
        taken  = 1'b0;
        case (req.op)
            opAdd, opSub: begin
                result = addSum;
            end
            opXor: begin
                result = req.a ^ req.b;
            end
            opAndn: begin
                result = req.a & ~req.b;
            end
            // Branches only raise the flag, result stays zero
            opBeqz: begin
                taken = (req.a == '0);
            end
            opBnez: begin
                taken = (req.a != '0);
            end
            opBltz: begin
                taken = req.a[31];
            end
            opBgez: begin
                taken = ~req.a[31];
            end
            opEq: begin
                result = {31'b0, diffZero};
            end
            opLt: begin
                result = {31'b0, lessThan};
            end
            opLe: begin
                result = {31'b0, lessEqual};
            end
            opPass: begin
                result = req.b;
            end
            // Low half of A above low half of B
            opSlbi: begin
                result = {req.a[15:0], req.b[15:0]};
            end
            default: begin
                result = '0;
                taken  = 1'b0;
            end
        endcase
    end

    assign resp = '{result: result, isTaken: taken};

endmodule

`default_nettype wire

// ==== design/cla32.sv ====
/*
  32-bit two-level carry-lookahead adder:
  eight cla4 slices and a lookahead unit for the slice carries
*/
`timescale 1ns/10ps
`default_nettype none

module cla32 import aluPkg::*; (
    input  wordT a,
    input  wordT b,
    input  logic cin,
    output wordT sum
);

    logic [7:0] pGrp;
    logic [7:0] gGrp;
    logic [7:0] sliceCin;
    logic       term;
    logic       carry;

    for (genvar i = 0; i < 8; i++) begin : gSlice
        cla4 uSlice (
            .a      (a[4*i +: 4]),
            .b      (b[4*i +: 4]),
            .cin    (sliceCin[i]),
            .sum    (sum[4*i +: 4]),
            .pGroup (pGrp[i]),
            .gGroup (gGrp[i])
        );
    end

    // Second level: every slice carry is a sum of products of the
    // group terms and cin, so no carry ripples from slice to slice
    always_comb begin
        term  = 1'b0;
        carry = 1'b0;
        for (int k = 0; k < 8; k++) begin
            // cin propagated through all lower slices
            term = cin;
            for (int m = 0; m < k; m++) begin
                term = term & pGrp[m];
            end
            carry = term;
            // Generate in slice j, propagated through j+1 .. k-1
            for (int j = 0; j < k; j++) begin
                term = gGrp[j];
                for (int m = j + 1; m < k; m++) begin
                    term = term & pGrp[m];
                end
                carry = carry | term;
            end
            sliceCin[k] = carry;
        end
    end

endmodule

`default_nettype wire

// ==== design/cla4.sv ====
/*
  4-bit carry-lookahead slice with group propagate/generate
*/
`timescale 1ns/10ps
`default_nettype none

module cla4 (
    input  logic [3:0] a,
    input  logic [3:0] b,
    input  logic       cin,
    output logic [3:0] sum,
    output logic       pGroup,
    output logic       gGroup
);

    logic [3:0] p;
    logic [3:0] g;
    logic [3:0] c;

    // Bit propagate and generate
    assign p = a ^ b;
    assign g = a & b;

    // Lookahead carries inside the slice
    assign c[0] = cin;
    assign c[1] = g[0] | (p[0] & cin);
    assign c[2] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
    assign c[3] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0])
                | (p[2] & p[1] & p[0] & cin);

    assign sum = p ^ c;

    // Group terms for the second lookahead level
    assign pGroup = &p;
    assign gGroup = g[3]
                  | (p[3] & g[2])
                  | (p[3] & p[2] & g[1])
                  | (p[3] & p[2] & p[1] & g[0]);

endmodule

`default_nettype wire

// ==== design/aluPkg.sv ====
/*
  Shared definitions for the APB ALU peripheral:
  word, opcode and register-offset types with their values,
  ALU request/response structs, APB access FSM states
*/
`default_nettype none

package aluPkg;

    typedef logic [31:0] wordT;
    typedef logic [3:0]  opCodeT;
    typedef logic [4:0]  regAddrT;

    // ALU opcodes, 13 to 15 unused
    localparam opCodeT opAdd  = 4'd0;
    localparam opCodeT opSub  = 4'd1;
    localparam opCodeT opXor  = 4'd2;
    localparam opCodeT opAndn = 4'd3;
    localparam opCodeT opBeqz = 4'd4;
    localparam opCodeT opBnez = 4'd5;
    localparam opCodeT opBltz = 4'd6;
    localparam opCodeT opBgez = 4'd7;
    localparam opCodeT opEq   = 4'd8;
    localparam opCodeT opLt   = 4'd9;
    localparam opCodeT opLe   = 4'd10;
    localparam opCodeT opPass = 4'd11;
    localparam opCodeT opSlbi = 4'd12;

    // APB register offsets
    localparam regAddrT addrOpA    = 5'h00;
    localparam regAddrT addrOpB    = 5'h04;
    localparam regAddrT addrCmd    = 5'h08;
    localparam regAddrT addrResult = 5'h0C;
    localparam regAddrT addrStatus = 5'h10;

    typedef struct packed {
        wordT   a;
        wordT   b;
        opCodeT op;
    } aluReqT;

    typedef struct packed {
        wordT result;
        logic isTaken;
    } aluRespT;

    typedef enum logic {stIdle, stExec} accessStateT;

endpackage

`default_nettype wire
